// ==== common/riscv_pkg.sv ====
// Shared constants, width types, ALU enum and pipeline structs, imported by every core module
package riscv_pkg;

  //////////////////////////////////////////////////
  // Widths and reset values
  //////////////////////////////////////////////////

  localparam int XLEN         = 32;
  localparam int ILEN         = 32;
  localparam int AR_BITS      = 5;
  localparam int DU_ADDR_SIZE = 12;

  typedef logic [XLEN-1:0]         xlen_t;
  typedef logic [ILEN-1:0]         instr_t;
  typedef logic [AR_BITS-1:0]      reg_addr_t;
  typedef logic [DU_ADDR_SIZE-1:0] du_addr_t;

  localparam xlen_t    PC_INIT    = 32'h0000_0200;
  // 0x000..0x01F select x0..x31
  localparam du_addr_t DU_PC_ADDR = 12'h020;

  // Major opcodes handled by the core
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  //////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    instr_t instr;
  } fetch_s;

  typedef struct packed {
    logic      valid;
    alu_op_e   op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     imm;
    logic      use_imm;
    logic      lui;
    logic      we;
  } decoded_s;

  typedef struct packed {
    logic      valid;
    logic      we;
    reg_addr_t rd;
    xlen_t     value;
  } wb_s;

endpackage

// ==== rtl/riscv_rf.sv ====
// Integer register file, two combinational read ports, written from write-back or debug
`timescale 1ns/10ps

module riscv_rf import riscv_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  reg_addr_t rf_src1_i,
  input  reg_addr_t rf_src2_i,
  output xlen_t     rf_srcv1_o,
  output xlen_t     rf_srcv2_o,
  input  wb_s       wb_i,
  input  logic      du_we_rf_i,
  input  du_addr_t  du_addr_i,
  input  xlen_t     du_dato_i,
  output xlen_t     du_dati_rf_o
);

  xlen_t     regs [1:31];
  reg_addr_t du_reg;

  assign du_reg = du_addr_i[AR_BITS-1:0];

  always_ff @(posedge clk_i) begin
    if (wb_i.valid && wb_i.we && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.value;
    end else if (du_we_rf_i && du_reg != '0) begin
      regs[du_reg] <= du_dato_i;
    end
  end

  // x0 is hardwired to zero
  assign rf_srcv1_o   = (rf_src1_i == '0) ? '0 : regs[rf_src1_i];
  assign rf_srcv2_o   = (rf_src2_i == '0) ? '0 : regs[rf_src2_i];
  assign du_dati_rf_o = (du_reg == '0) ? '0 : regs[du_reg];

  a_single_writer: assert property (@(posedge clk_i) disable iff (reset_i)
    !(du_we_rf_i && wb_i.valid && wb_i.we));

endmodule

// ==== core/riscv_if.sv ====
// Instruction fetch unit, issues one sequential request at a time and hands parcels to decode
`timescale 1ns/10ps

module riscv_if import riscv_pkg::*; (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   du_stall_i,
  input  logic   du_we_pc_i,
  input  xlen_t  du_dato_i,
  input  instr_t if_parcel_i,
  input  logic   if_parcel_valid_i,
  output logic   if_req_o,
  output xlen_t  if_nxt_pc_o,
  output logic   if_idle_o,
  output fetch_s fetch_o
);

  typedef enum logic {IDLE, WAIT} if_state_e;

  if_state_e state_q, state_d;
  xlen_t     pc_q;
  fetch_s    fetch_q;
  logic      accept;

  assign accept = (state_q == WAIT) && if_parcel_valid_i;

  // A stall only takes effect between requests
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (!du_stall_i) state_d = WAIT;
      WAIT: if (accept && du_stall_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      pc_q    <= PC_INIT;
    end else begin
      state_q <= state_d;
      if (accept) begin
        pc_q <= pc_q + xlen_t'(4);
      end else if (state_q == IDLE && du_we_pc_i) begin
        pc_q <= du_dato_i;
      end
    end
  end

  // Capture parcel together with the PC it was fetched from
  always_ff @(posedge clk_i) begin
    if (accept) begin
      fetch_q.pc    <= pc_q;
      fetch_q.instr <= if_parcel_i;
    end
    fetch_q.valid <= reset_i ? 1'b0 : accept;
  end

  assign if_req_o    = (state_q == WAIT);
  assign if_nxt_pc_o = pc_q;
  assign if_idle_o   = (state_q == IDLE);
  assign fetch_o     = fetch_q;

  // Request and address held until the memory returns the parcel
  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == WAIT && !if_parcel_valid_i) |=> (if_req_o && $stable(if_nxt_pc_o)));

endmodule

// ==== core/riscv_id.sv ====
// Decode stage, turns a fetched RV32I instruction into registered control fields for execute
`timescale 1ns/10ps

module riscv_id import riscv_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  fetch_s   fetch_i,
  output decoded_s id_o
);

  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  decoded_s   dec;
  decoded_s   id_q;

  // funct3 to ALU op, alt selects SUB or SRA
  function automatic alu_op_e alu_sel(logic [2:0] f3, logic alt_add, logic alt_shr);
    case (f3)
      3'b000:  return alt_add ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt_shr ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign instr  = fetch_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    dec         = '0;
    dec.valid   = fetch_i.valid;
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.rd      = instr[11:7];
    dec.imm     = {{20{instr[31]}}, instr[31:20]};
    dec.op      = alu_sel(funct3, 1'b0, instr[30]);
    legal       = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        dec.use_imm = 1'b1;
        legal       = 1'b1;
        // Shifts take a 5-bit shamt, funct7 may only carry the SRA bit
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          dec.imm = {27'b0, instr[24:20]};
          legal   = (funct7 & 7'b1011111) == 7'b0 && !(funct3 == 3'b001 && instr[30]);
        end
      end
      OPC_OP: begin
        dec.op = alu_sel(funct3, instr[30], instr[30]);
        legal  = (funct7 == 7'b0) ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_LUI: begin
        dec.lui = 1'b1;
        dec.imm = {instr[31:12], 12'b0};
        legal   = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    // Anything else, and writes to x0, retire without effect
    dec.we = legal && (dec.rd != '0);
  end

  always_ff @(posedge clk_i) begin
    id_q <= dec;
    if (reset_i) begin
      id_q.valid <= 1'b0;
      id_q.we    <= 1'b0;
    end
  end

  assign id_o = id_q;

endmodule

// ==== core/riscv_ex.sv ====
// Execute stage, forwards the write-back result, runs the ALU and holds the write-back register
`timescale 1ns/10ps

module riscv_ex import riscv_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  decoded_s  id_i,
  output reg_addr_t rf_src1_o,
  output reg_addr_t rf_src2_o,
  input  xlen_t     rf_srcv1_i,
  input  xlen_t     rf_srcv2_i,
  output wb_s       wb_o
);

  xlen_t      src1, src2;
  xlen_t      op_a, op_b;
  xlen_t      alu_res;
  logic [4:0] shamt;
  wb_s        wb_d, wb_q;

  // Result still in write-back wins over the register file
  function automatic xlen_t bypass(reg_addr_t rs, xlen_t rf_val, wb_s wb);
    if (wb.valid && wb.we && wb.rd == rs && rs != '0) return wb.value;
    return rf_val;
  endfunction

  assign rf_src1_o = id_i.rs1;
  assign rf_src2_o = id_i.rs2;

  assign src1  = bypass(id_i.rs1, rf_srcv1_i, wb_q);
  assign src2  = bypass(id_i.rs2, rf_srcv2_i, wb_q);
  assign op_a  = src1;
  assign op_b  = id_i.use_imm ? id_i.imm : src2;
  assign shamt = op_b[4:0];

  always_comb begin
    case (id_i.op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_res = op_a | op_b;
      default:  alu_res = op_a & op_b;
    endcase
  end

  always_comb begin
    wb_d.valid = id_i.valid;
    wb_d.we    = id_i.valid && id_i.we;
    wb_d.rd    = id_i.rd;
    wb_d.value = id_i.lui ? id_i.imm : alu_res;
  end

  always_ff @(posedge clk_i) begin
    wb_q <= wb_d;
    if (reset_i) begin
      wb_q.valid <= 1'b0;
      wb_q.we    <= 1'b0;
    end
  end

  assign wb_o = wb_q;

  // Decode must have filtered x0 destinations
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (reset_i)
    (id_i.valid && id_i.we) |=> (wb_q.rd != '0));

endmodule

// ==== debug/riscv_du.sv ====
// Debug unit, stalls and drains the core, then serves register and next-PC accesses
`timescale 1ns/10ps

module riscv_du import riscv_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     dbg_stall_i,
  input  logic     dbg_strb_i,
  input  logic     dbg_we_i,
  input  du_addr_t dbg_addr_i,
  input  xlen_t    dbg_dati_i,
  output xlen_t    dbg_dato_o,
  output logic     dbg_ack_o,
  input  logic     if_idle_i,
  input  fetch_s   fetch_i,
  input  decoded_s id_i,
  input  wb_s      wb_i,
  input  xlen_t    du_dati_rf_i,
  output logic     du_stall_o,
  output logic     du_we_rf_o,
  output logic     du_we_pc_o,
  output du_addr_t du_addr_o,
  output xlen_t    du_dato_o
);

  typedef enum logic [1:0] {RUN, HALTED, ACK} du_state_e;

  du_state_e state_q, state_d;
  logic      drained;
  logic      access;
  logic      sel_rf, sel_pc;
  xlen_t     nxt_pc_q;
  xlen_t     dato_q;

  //////////////////////////////////////////////////
  // Halt control
  //////////////////////////////////////////////////

  // Nothing in flight anywhere in the pipe
  assign drained = if_idle_i && !fetch_i.valid && !id_i.valid && !wb_i.valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN:    if (dbg_stall_i && drained) state_d = HALTED;
      HALTED: begin
        if (!dbg_stall_i) begin
          state_d = RUN;
        end else if (dbg_strb_i) begin
          state_d = ACK;
        end
      end
      default: state_d = HALTED;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////

  assign sel_rf = (dbg_addr_i[DU_ADDR_SIZE-1:AR_BITS] == '0);
  assign sel_pc = (dbg_addr_i == DU_PC_ADDR);
  // One cycle per strobe, the next state is ACK
  assign access = (state_q == HALTED) && dbg_stall_i && dbg_strb_i;

  assign du_we_rf_o = access && dbg_we_i && sel_rf;
  assign du_we_pc_o = access && dbg_we_i && sel_pc;
  assign du_addr_o  = dbg_addr_i;
  assign du_dato_o  = dbg_dati_i;
  assign du_stall_o = dbg_stall_i || (state_q != RUN);

  // Shadow of the next fetch address
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      nxt_pc_q <= PC_INIT;
    end else if (du_we_pc_o) begin
      nxt_pc_q <= dbg_dati_i;
    end else if (fetch_i.valid) begin
      nxt_pc_q <= fetch_i.pc + xlen_t'(4);
    end
  end

  // Unmapped addresses read as zero
  always_ff @(posedge clk_i) begin
    if (access) begin
      dato_q <= sel_pc ? nxt_pc_q : (sel_rf ? du_dati_rf_i : '0);
    end
  end

  assign dbg_dato_o = dato_q;
  assign dbg_ack_o  = (state_q == ACK);

  // Pipe must stay empty for as long as the host owns the core
  a_halted_drained: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q != RUN) |-> drained);

endmodule

// ==== rtl/riscv_core.sv ====
// Core top level, connects fetch, decode, execute, register file and debug unit
`timescale 1ns/10ps

module riscv_core import riscv_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // Instruction bus
  output logic     if_req_o,
  output xlen_t    if_nxt_pc_o,
  input  instr_t   if_parcel_i,
  input  logic     if_parcel_valid_i,
  // Debug bus
  input  logic     dbg_stall_i,
  input  logic     dbg_strb_i,
  input  logic     dbg_we_i,
  input  du_addr_t dbg_addr_i,
  input  xlen_t    dbg_dati_i,
  output xlen_t    dbg_dato_o,
  output logic     dbg_ack_o
);

  fetch_s    fetch;
  decoded_s  id;
  wb_s       wb;
  reg_addr_t rf_src1, rf_src2;
  xlen_t     rf_srcv1, rf_srcv2;
  logic      if_idle;
  logic      du_stall, du_we_rf, du_we_pc;
  du_addr_t  du_addr;
  xlen_t     du_dato, du_dati_rf;

  riscv_if if_unit (
    .clk_i, .reset_i,
    .du_stall_i(du_stall), .du_we_pc_i(du_we_pc), .du_dato_i(du_dato),
    .if_parcel_i, .if_parcel_valid_i, .if_req_o, .if_nxt_pc_o,
    .if_idle_o(if_idle), .fetch_o(fetch)
  );

  riscv_id id_unit (.clk_i, .reset_i, .fetch_i(fetch), .id_o(id));

  riscv_ex ex_unit (
    .clk_i, .reset_i, .id_i(id),
    .rf_src1_o(rf_src1), .rf_src2_o(rf_src2),
    .rf_srcv1_i(rf_srcv1), .rf_srcv2_i(rf_srcv2), .wb_o(wb)
  );

  riscv_rf rf_unit (
    .clk_i, .reset_i,
    .rf_src1_i(rf_src1), .rf_src2_i(rf_src2),
    .rf_srcv1_o(rf_srcv1), .rf_srcv2_o(rf_srcv2), .wb_i(wb),
    .du_we_rf_i(du_we_rf), .du_addr_i(du_addr), .du_dato_i(du_dato),
    .du_dati_rf_o(du_dati_rf)
  );

  riscv_du du_unit (
    .clk_i, .reset_i,
    .dbg_stall_i, .dbg_strb_i, .dbg_we_i, .dbg_addr_i, .dbg_dati_i, .dbg_dato_o, .dbg_ack_o,
    .if_idle_i(if_idle), .fetch_i(fetch), .id_i(id), .wb_i(wb), .du_dati_rf_i(du_dati_rf),
    .du_stall_o(du_stall), .du_we_rf_o(du_we_rf), .du_we_pc_o(du_we_pc),
    .du_addr_o(du_addr), .du_dato_o(du_dato)
  );

endmodule

// ==== tb/tb_riscv_core_tasks.svh ====
// Debug bus tasks, program loading, reference model and directed tests that the testbench top includes

  //////////////////////////////////////////////////
  // Encoders and checks
  //////////////////////////////////////////////////

  function automatic instr_t i_type(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                    logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic instr_t r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t lui(reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Debug bus
  //////////////////////////////////////////////////

  // Strobe held until the single ack cycle
  task automatic debug_strobe(input logic we, input du_addr_t addr, input xlen_t wdata,
                              output xlen_t rdata);
    @(posedge clk);
    #2;
    dbg_strb = 1'b1;
    dbg_we   = we;
    dbg_addr = addr;
    dbg_dati = wdata;
    do begin
      @(posedge clk);
      #2;
    end while (dbg_ack !== 1'b1);
    rdata    = dbg_dato;
    dbg_strb = 1'b0;
    dbg_we   = 1'b0;
  endtask

  task automatic dbg_write(input du_addr_t addr, input xlen_t data);
    xlen_t unused;
    debug_strobe(1'b1, addr, data, unused);
  endtask

  task automatic dbg_read(input du_addr_t addr, output xlen_t data);
    debug_strobe(1'b0, addr, '0, data);
  endtask

  task automatic set_reg(input int idx, input xlen_t val);
    dbg_write(du_addr_t'(idx), val);
    if (idx != 0) exp_regs[idx] = val;
  endtask

  task automatic init_regs();
    int i;
    exp_regs[0] = '0;
    for (i = 1; i < 32; i++) set_reg(i, 32'h9e37_79b9 * i);
  endtask

  task automatic check_regs(input string name);
    xlen_t val;
    int    i;
    for (i = 0; i < 32; i++) begin
      dbg_read(du_addr_t'(i), val);
      check_value($sformatf("%s x%0d", name, i), exp_regs[i], val);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model and program runs
  //////////////////////////////////////////////////

  // RV32I semantics for OP-IMM, OP and LUI while any other opcode changes nothing
  task automatic model_step(input instr_t ins);
    logic [6:0] opc;
    logic [2:0] f3;
    xlen_t      a, b, r;
    logic       wr;
    opc = ins[6:0];
    f3  = ins[14:12];
    a   = exp_regs[ins[19:15]];
    b   = (opc == 7'b0110011) ? exp_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    wr  = (opc == 7'b0010011) || (opc == 7'b0110011);
    case (f3)
      3'd0: r = (opc == 7'b0110011 && ins[30]) ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (ins[30]) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (opc == 7'b0110111) begin
      r  = {ins[31:12], 12'b0};
      wr = 1'b1;
    end
    if (wr && ins[11:7] != 5'd0) exp_regs[ins[11:7]] = r;
  endtask

  // Program at base and a plain NOP where the run stops
  task automatic load_program(input xlen_t base);
    int i;
    for (i = 0; i < prog.size(); i++) imem[base[10:2] + i] = prog[i];
    imem[base[10:2] + prog.size()] = 32'h0000_0013;
  endtask

  // Release the core at base and stall it again once end_pc is requested
  task automatic run_program(input xlen_t base, input xlen_t end_pc);
    logic first;
    dbg_write(DU_PC_ADDR, base);
    first = 1'b1;
    @(posedge clk);
    #2;
    dbg_stall = 1'b0;
    do begin
      @(posedge clk);
      #2;
      if (req && first) begin
        check_value("first request after PC write", base, nxt_pc);
        first = 1'b0;
      end
    end while (!(req && nxt_pc == end_pc));
    dbg_stall = 1'b1;
  endtask

  task automatic exec_and_check(input string name, input xlen_t base);
    int i;
    load_program(base);
    for (i = 0; i < prog.size(); i++) model_step(prog[i]);
    run_program(base, base + xlen_t'(4 * prog.size()));
    check_regs(name);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic check_reset_fetch();
    int i;
    // Core runs freely over the fill pattern
    while (req_log.size() < 8) begin
      @(posedge clk);
      #2;
      checks++;
      if (dbg_ack !== 1'b0) begin
        errors++;
        $display("Error in reset: debug ack raised with no debug access");
      end
    end
    dbg_stall = 1'b1;
    check_value("reset first request", PC_INIT, req_log[0]);
    for (i = 1; i < 8; i++) begin
      check_value("reset request order", PC_INIT + xlen_t'(4 * i), req_log[i]);
    end
  endtask

  task automatic run_imm_group();
    prog.delete();
    prog.push_back(lui(5'd1, 20'h80000));
    prog.push_back(i_type(3'b000, 5'd2, 5'd0, 12'hffb));
    prog.push_back(i_type(3'b000, 5'd3, 5'd1, 12'h7ff));
    prog.push_back(i_type(3'b010, 5'd4, 5'd2, 12'hffc));
    prog.push_back(i_type(3'b011, 5'd5, 5'd2, 12'h003));
    prog.push_back(i_type(3'b011, 5'd13, 5'd1, 12'hfff));
    prog.push_back(i_type(3'b100, 5'd6, 5'd3, 12'hfff));
    prog.push_back(i_type(3'b110, 5'd7, 5'd2, 12'h123));
    prog.push_back(i_type(3'b111, 5'd8, 5'd6, 12'h0f0));
    prog.push_back(i_type(3'b001, 5'd9, 5'd2, 12'h004));
    prog.push_back(i_type(3'b101, 5'd10, 5'd1, 12'h003));
    prog.push_back(i_type(3'b101, 5'd11, 5'd1, 12'h403));   // SRAI of a negative value
    prog.push_back(lui(5'd12, 20'h12345));
    prog.push_back(i_type(3'b000, 5'd12, 5'd12, 12'h678));
    prog.push_back(i_type(3'b000, 5'd0, 5'd12, 12'h001));
    init_regs();
    exec_and_check("imm_group", PC_INIT);
  endtask

  // Each result feeds the next instructions directly
  task automatic run_reg_group(input string name);
    prog.delete();
    prog.push_back(i_type(3'b000, 5'd1, 5'd0, 12'hff9));
    prog.push_back(i_type(3'b000, 5'd2, 5'd0, 12'h003));
    prog.push_back(r_type(7'h20, 3'b000, 5'd3, 5'd2, 5'd1));
    prog.push_back(r_type(7'h00, 3'b010, 5'd4, 5'd1, 5'd2));
    prog.push_back(r_type(7'h00, 3'b011, 5'd5, 5'd1, 5'd2));
    prog.push_back(r_type(7'h20, 3'b101, 5'd6, 5'd1, 5'd2));
    prog.push_back(r_type(7'h00, 3'b101, 5'd7, 5'd1, 5'd2));
    prog.push_back(r_type(7'h00, 3'b001, 5'd8, 5'd3, 5'd2));
    prog.push_back(r_type(7'h00, 3'b000, 5'd9, 5'd8, 5'd3));
    prog.push_back(r_type(7'h00, 3'b100, 5'd10, 5'd9, 5'd1));
    prog.push_back(r_type(7'h00, 3'b110, 5'd11, 5'd10, 5'd2));
    prog.push_back(r_type(7'h00, 3'b111, 5'd12, 5'd11, 5'd6));
    prog.push_back(r_type(7'h20, 3'b000, 5'd13, 5'd12, 5'd13));
    prog.push_back(r_type(7'h20, 3'b101, 5'd14, 5'd13, 5'd9));
    prog.push_back(r_type(7'h00, 3'b000, 5'd14, 5'd14, 5'd14));
    init_regs();
    exec_and_check(name, PC_INIT);
  endtask

  task automatic check_debug_access();
    xlen_t val;
    prog.delete();
    set_reg(5, 32'hcafe_f00d);
    set_reg(6, 32'h0000_0008);
    prog.push_back(r_type(7'h00, 3'b000, 5'd7, 5'd5, 5'd6));
    prog.push_back(r_type(7'h20, 3'b101, 5'd8, 5'd5, 5'd6));
    exec_and_check("debug_write_used", 32'h0000_0300);
    dbg_write(12'h000, 32'hdead_beef);
    dbg_read(12'h000, val);
    check_value("debug_x0", '0, val);
    dbg_write(DU_PC_ADDR, 32'h0000_0400);
    dbg_read(DU_PC_ADDR, val);
    check_value("debug_pc_read", 32'h0000_0400, val);
    prog.delete();
    prog.push_back(i_type(3'b100, 5'd9, 5'd7, 12'h5a5));
    exec_and_check("debug_pc_write", 32'h0000_0400);
  endtask

// ==== tb/tb_riscv_core.sv ====
// Testbench top for the RV32I core, runs directed tests through the fetch and debug buses
`timescale 1ns/10ps

module tb_riscv_core import riscv_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int IMEM_WORDS = 512;
  localparam int N_TESTS    = 5;
  localparam int PROG_MAX   = 16;
  localparam int DBG_MAX    = 100;
  // Three wait cycles plus the valid cycle
  localparam int MAX_LAT    = 4;
  localparam int WD_CYCLES  = N_TESTS * (PROG_MAX + DBG_MAX) * MAX_LAT + 500;

  logic     clk;
  logic     reset;
  logic     req;
  xlen_t    nxt_pc;
  instr_t   parcel;
  logic     parcel_valid;
  logic     dbg_stall, dbg_strb, dbg_we, dbg_ack;
  du_addr_t dbg_addr;
  xlen_t    dbg_dati, dbg_dato;

  instr_t      imem [0:IMEM_WORDS-1];
  xlen_t       req_log[$];
  instr_t      prog[$];
  xlen_t       exp_regs [0:31];
  logic        rand_delay;
  logic [31:0] rng_state;
  int unsigned checks, errors;

  riscv_core u_dut (
    .clk_i(clk), .reset_i(reset),
    .if_req_o(req), .if_nxt_pc_o(nxt_pc),
    .if_parcel_i(parcel), .if_parcel_valid_i(parcel_valid),
    .dbg_stall_i(dbg_stall), .dbg_strb_i(dbg_strb), .dbg_we_i(dbg_we), .dbg_addr_i(dbg_addr),
    .dbg_dati_i(dbg_dati), .dbg_dato_o(dbg_dato), .dbg_ack_o(dbg_ack)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // ADDI x0 no-op whose immediate folds in every address bit
  function automatic instr_t fill_word(xlen_t addr);
    return {addr[11:0] ^ addr[23:12] ^ {4'b0, addr[31:24]}, 20'h00013};
  endfunction

  function automatic instr_t imem_read(xlen_t addr);
    if (addr < xlen_t'(IMEM_WORDS * 4)) return imem[addr[10:2]];
    return fill_word(addr);
  endfunction

  `include "tb_riscv_core_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Instruction memory, one request at a time, valid after 0 to 3 wait cycles
  initial begin : imem_model
    int unsigned wait_left;
    logic        busy;
    xlen_t       req_pc;
    busy      = 1'b0;
    wait_left = 0;
    req_pc    = '0;
    forever begin
      @(posedge clk);
      #2;
      // A parcel shown last cycle was taken at this edge
      if (parcel_valid) begin
        parcel_valid = 1'b0;
        busy         = 1'b0;
      end
      if (req && !busy) begin
        busy      = 1'b1;
        req_pc    = nxt_pc;
        wait_left = rand_delay ? next_rand() % 4 : 0;
        req_log.push_back(req_pc);
      end
      if (busy) begin
        if (wait_left == 0) begin
          parcel       = imem_read(req_pc);
          parcel_valid = 1'b1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin : watchdog
    #(WD_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish", WD_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main_seq
    int i;
    reset        = 1'b1;
    parcel       = '0;
    parcel_valid = 1'b0;
    dbg_stall    = 1'b0;
    dbg_strb     = 1'b0;
    dbg_we       = 1'b0;
    dbg_addr     = '0;
    dbg_dati     = '0;
    rand_delay   = 1'b0;
    rng_state    = 32'hd0e40bd8;
    checks       = 0;
    errors       = 0;
    for (i = 0; i < IMEM_WORDS; i++) imem[i] = fill_word(xlen_t'(i * 4));
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    checks++;
    if (req !== 1'b0) begin
      errors++;
      $display("Error in reset: fetch request raised in the first cycle after reset");
    end
    check_reset_fetch();
    run_imm_group();
    run_reg_group("reg_group");
    rand_delay = 1'b1;
    run_reg_group("random_latency");
    rand_delay = 1'b0;
    check_debug_access();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tb
common/riscv_pkg.sv
rtl/riscv_rf.sv
core/riscv_if.sv
core/riscv_id.sv
core/riscv_ex.sv
debug/riscv_du.sv
rtl/riscv_core.sv
tb/tb_riscv_core.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - common/riscv_pkg.sv
  - rtl/riscv_rf.sv
  - core/riscv_if.sv
  - core/riscv_id.sv
  - core/riscv_ex.sv
  - debug/riscv_du.sv
  - rtl/riscv_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_riscv_core.sv
